//--- hdl/cfu_pkg.sv
// shared widths, opcodes and the structs that link the front end to its units
// the opcode is funct3 only; funct7 carries nothing in this design
// funct3 values 5..7 all decode to op_none
`default_nettype none

package cfu_pkg;

  ////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////

  // operand and result width
  localparam int unsigned data_w = 32;
  // full function id from the core
  localparam int unsigned func_id_w = 10;
  // funct3 sits in the low bits of the function id
  localparam int unsigned funct3_w = 3;
  // instruction store geometry
  localparam int unsigned instr_addr_w = 9;
  localparam int unsigned instr_depth = 512;

  ////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////

  // core-visible opcode, decoded from funct3
  typedef enum logic [funct3_w-1:0] {
    op_byte_sum    = 3'd0,
    op_byte_swap   = 3'd1,
    op_bit_reverse = 3'd2,
    op_instr_write = 3'd3,
    op_instr_read  = 3'd4,
    // stands for every unassigned funct3 value
    op_none        = 3'd5
  } cfu_op_e;

  // operation carried to the SIMD byte ALU
  typedef enum logic [1:0] {
    alu_sum     = 2'd0,
    alu_swap    = 2'd1,
    alu_reverse = 2'd2,
    alu_zero    = 2'd3
  } alu_op_e;

  ////////////////////////////////////////
  // issue and result bundles
  ////////////////////////////////////////

  // work for the ALU, 67 bits
  typedef struct packed {
    logic              valid;
    alu_op_e           op;
    logic [data_w-1:0] operand_a;
    logic [data_w-1:0] operand_b;
  } alu_issue_t;

  // work for the instruction store, 43 bits
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [instr_addr_w-1:0] addr;
    logic [data_w-1:0]       wdata;
  } store_issue_t;

  // answer from either unit, 33 bits
  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] data;
  } unit_result_t;

endpackage

`default_nettype wire

//--- hdl/simd_byte_alu.sv
// SIMD byte ALU, one registered cycle from issue to result
// sum covers all eight operand bytes, swap and reverse use operand_a only
`default_nettype none

module simd_byte_alu (
  input  logic                  clk,
  input  logic                  resetn,
  input  cfu_pkg::alu_issue_t   alu_issue,
  output cfu_pkg::unit_result_t alu_result
);
  import cfu_pkg::*;

  logic              res_valid_q;
  logic [data_w-1:0] res_data_q;
  logic [data_w-1:0] byte_sum;
  logic [data_w-1:0] alu_out;

  // unsigned sum of both operands' bytes, zero extended
  always_comb begin
    byte_sum = '0;
    for (int i = 0; i < data_w / 8; i++) begin
      byte_sum = byte_sum + data_w'(alu_issue.operand_a[i*8 +: 8])
                          + data_w'(alu_issue.operand_b[i*8 +: 8]);
    end
  end

  ////////////////////////////////////////
  // operation select
  ////////////////////////////////////////
  always_comb begin
    case (alu_issue.op)
      alu_sum:     alu_out = byte_sum;
      // byte order reversed
      alu_swap:    alu_out = {<<8{alu_issue.operand_a}};
      // bit order reversed
      alu_reverse: alu_out = {<<{alu_issue.operand_a}};
      default:     alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= alu_issue.valid;
    end
  end

  // data only moves on an issue
  always_ff @(posedge clk) begin
    if (alu_issue.valid) begin
      res_data_q <= alu_out;
    end
  end

  assign alu_result = '{valid: res_valid_q, data: res_data_q};

endmodule

`default_nettype wire

//--- hdl/instr_store.sv
// 512 x 32 single-port instruction store
// write result (all ones) one cycle after issue, read data two cycles after
// contents are undefined until written; no reset of the array
`default_nettype none

module instr_store (
  input  logic                  clk,
  input  logic                  resetn,
  input  cfu_pkg::store_issue_t store_issue,
  output cfu_pkg::unit_result_t store_result
);
  import cfu_pkg::*;

  logic [data_w-1:0] mem [instr_depth];
  logic [data_w-1:0] rd_data_q;
  logic              rd_pend_q;
  logic              res_valid_q;
  logic [data_w-1:0] res_data_q;
  logic              wr_issue;
  logic              rd_issue;

  assign wr_issue = store_issue.valid && store_issue.write;
  assign rd_issue = store_issue.valid && !store_issue.write;

  ////////////////////////////////////////
  // memory array
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_issue) begin
      mem[store_issue.addr] <= store_issue.wdata;
    end
    // first read stage is the memory output register
    if (rd_issue) begin
      rd_data_q <= mem[store_issue.addr];
    end
  end

  // valid shift: rd_pend is stage one, res_valid stage two
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rd_pend_q   <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      rd_pend_q   <= rd_issue;
      res_valid_q <= wr_issue || rd_pend_q;
    end
  end

  // output register, write completion answers with all ones
  always_ff @(posedge clk) begin
    if (wr_issue) begin
      res_data_q <= '1;
    end else if (rd_pend_q) begin
      res_data_q <= rd_data_q;
    end
  end

  assign store_result = '{valid: res_valid_q, data: res_data_q};

  // front end holds one command at a time, so a read never meets a write
  a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
    !(rd_pend_q && wr_issue));

endmodule

`default_nettype wire

//--- hdl/cfu_front_end.sv
// command/response front end for the custom function unit
// one command in flight; cmd_ready stays low until the response is taken
// funct7 (function id bits above funct3) is ignored
// units return one result pulse per issue and never two at once
`default_nettype none

module cfu_front_end (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         cmd_valid,
  output logic                         cmd_ready,
  input  logic [cfu_pkg::func_id_w-1:0] cmd_payload_function_id,
  input  logic [cfu_pkg::data_w-1:0]   cmd_payload_inputs_0,
  input  logic [cfu_pkg::data_w-1:0]   cmd_payload_inputs_1,
  output logic                         rsp_valid,
  input  logic                         rsp_ready,
  output logic [cfu_pkg::data_w-1:0]   rsp_payload_outputs_0,
  output cfu_pkg::alu_issue_t          alu_issue,
  output cfu_pkg::store_issue_t        store_issue,
  input  cfu_pkg::unit_result_t        alu_result,
  input  cfu_pkg::unit_result_t        store_result
);
  import cfu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_respond
  } state_e;

  state_e                  state;
  cfu_op_e                 op;
  logic                    accept;
  logic                    result_valid;
  logic                    alu_valid_q;
  logic                    store_valid_q;
  alu_op_e                 alu_op_q;
  logic                    store_write_q;
  logic [data_w-1:0]       operand_a_q;
  logic [data_w-1:0]       operand_b_q;
  logic [data_w-1:0]       rsp_data_q;

  // funct3 values above instr_read all map to op_none
  assign op = (cmd_payload_function_id[funct3_w-1:0] > 3'd4) ?
              op_none : cfu_op_e'(cmd_payload_function_id[funct3_w-1:0]);

  // handshake is a pure decode of the state
  assign cmd_ready    = (state == st_idle);
  assign rsp_valid    = (state == st_respond);
  assign accept       = cmd_valid && cmd_ready;
  assign result_valid = alu_result.valid || store_result.valid;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state         <= st_idle;
      alu_valid_q   <= 1'b0;
      store_valid_q <= 1'b0;
    end else begin
      // issue valids are single-cycle pulses
      alu_valid_q   <= 1'b0;
      store_valid_q <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_busy;
            // writes and reads go to the store, everything else to the ALU
            if (op == op_instr_write || op == op_instr_read) begin
              store_valid_q <= 1'b1;
            end else begin
              alu_valid_q <= 1'b1;
            end
          end
        end
        st_busy: begin
          if (result_valid) begin
            state <= st_respond;
          end
        end
        default: begin
          if (rsp_ready) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // payload registers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (accept) begin
      operand_a_q   <= cmd_payload_inputs_0;
      operand_b_q   <= cmd_payload_inputs_1;
      store_write_q <= (op == op_instr_write);
      case (op)
        op_byte_sum:    alu_op_q <= alu_sum;
        op_byte_swap:   alu_op_q <= alu_swap;
        op_bit_reverse: alu_op_q <= alu_reverse;
        default:        alu_op_q <= alu_zero;
      endcase
    end
    // combine the two units; only one can answer at a time
    if (result_valid) begin
      rsp_data_q <= alu_result.valid ? alu_result.data : store_result.data;
    end
  end

  assign alu_issue   = '{valid: alu_valid_q, op: alu_op_q,
                         operand_a: operand_a_q, operand_b: operand_b_q};
  // store address is the low bits of inputs_0
  assign store_issue = '{valid: store_valid_q, write: store_write_q,
                         addr: operand_a_q[instr_addr_w-1:0], wdata: operand_b_q};
  assign rsp_payload_outputs_0 = rsp_data_q;

  // a stalled response keeps its payload and the command slot stays closed
  a_rsp_hold: assert property (@(posedge clk) disable iff (!resetn)
    rsp_valid && !rsp_ready |=>
      rsp_valid && !cmd_ready && $stable(rsp_payload_outputs_0));

  // the units must never answer in the same cycle
  a_one_result: assert property (@(posedge clk) disable iff (!resetn)
    !(alu_result.valid && store_result.valid));

endmodule

`default_nettype wire

//--- hdl/cfu_top.sv
// custom function unit top: front end plus SIMD byte ALU and instruction store
// ALU ops, writes and unassigned opcodes answer 2 edges after acceptance
// instruction reads answer 3 edges after acceptance
// response is held until rsp_ready; funct7 is ignored
`default_nettype none

module cfu_top (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          cmd_valid,
  output logic                          cmd_ready,
  input  logic [cfu_pkg::func_id_w-1:0] cmd_payload_function_id,
  input  logic [cfu_pkg::data_w-1:0]    cmd_payload_inputs_0,
  input  logic [cfu_pkg::data_w-1:0]    cmd_payload_inputs_1,
  output logic                          rsp_valid,
  input  logic                          rsp_ready,
  output logic [cfu_pkg::data_w-1:0]    rsp_payload_outputs_0
);
  import cfu_pkg::*;

  // issue paths out of the front end
  alu_issue_t   alu_issue;
  store_issue_t store_issue;
  // result paths back into it
  unit_result_t alu_result;
  unit_result_t store_result;

  ////////////////////////////////////////
  // front end
  ////////////////////////////////////////
  cfu_front_end u_front_end (
    .clk                     (clk),
    .resetn                  (resetn),
    .cmd_valid               (cmd_valid),
    .cmd_ready               (cmd_ready),
    .cmd_payload_function_id (cmd_payload_function_id),
    .cmd_payload_inputs_0    (cmd_payload_inputs_0),
    .cmd_payload_inputs_1    (cmd_payload_inputs_1),
    .rsp_valid               (rsp_valid),
    .rsp_ready               (rsp_ready),
    .rsp_payload_outputs_0   (rsp_payload_outputs_0),
    .alu_issue               (alu_issue),
    .store_issue             (store_issue),
    .alu_result              (alu_result),
    .store_result            (store_result)
  );

  ////////////////////////////////////////
  // execution units
  ////////////////////////////////////////
  simd_byte_alu u_alu (
    .clk        (clk),
    .resetn     (resetn),
    .alu_issue  (alu_issue),
    .alu_result (alu_result)
  );

  instr_store u_store (
    .clk          (clk),
    .resetn       (resetn),
    .store_issue  (store_issue),
    .store_result (store_result)
  );

endmodule

`default_nettype wire

//--- tests/tb_cfu.sv
// table-driven testbench for cfu_top with one command in flight at a time
// inputs change and outputs are sampled on the falling clock edge
// rsp_ready is held low for random stretches to exercise back-pressure
// instruction store reads only target addresses written earlier in the table
`default_nettype none

module tb_cfu;
  timeunit 1ns;
  timeprecision 1ps;

  // one stimulus row with its expected response
  typedef struct packed {
    logic [9:0]  func_id;
    logic [31:0] in0;
    logic [31:0] in1;
    logic [31:0] expected;
  } vec_t;

  logic        clk;
  logic        resetn;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [9:0]  cmd_payload_function_id;
  logic [31:0] cmd_payload_inputs_0;
  logic [31:0] cmd_payload_inputs_1;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_payload_outputs_0;

  vec_t vectors[$];

  cfu_top u_dut (
    .clk                     (clk),
    .resetn                  (resetn),
    .cmd_valid               (cmd_valid),
    .cmd_ready               (cmd_ready),
    .cmd_payload_function_id (cmd_payload_function_id),
    .cmd_payload_inputs_0    (cmd_payload_inputs_0),
    .cmd_payload_inputs_1    (cmd_payload_inputs_1),
    .rsp_valid               (rsp_valid),
    .rsp_ready               (rsp_ready),
    .rsp_payload_outputs_0   (rsp_payload_outputs_0)
  );

  // 4 ns period
  always #2 clk = ~clk;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // unsigned sum of all eight bytes
  function automatic logic [31:0] sum_bytes(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] total;
    total = 32'd0;
    for (int i = 0; i < 4; i++) begin
      total = total + {24'd0, a[8*i +: 8]} + {24'd0, b[8*i +: 8]};
    end
    return total;
  endfunction

  function automatic logic [31:0] swap_bytes(input logic [31:0] a);
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  function automatic logic [31:0] reverse_bits(input logic [31:0] a);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
      r[i] = a[31-i];
    end
    return r;
  endfunction

  // expected answer of an ALU-side opcode where 5..7 give zero
  function automatic logic [31:0] alu_expect(input logic [2:0] funct3,
                                             input logic [31:0] a, input logic [31:0] b);
    case (funct3)
      3'd0: return sum_bytes(a, b);
      3'd1: return swap_bytes(a);
      3'd2: return reverse_bits(a);
      default: return 32'd0;
    endcase
  endfunction

  ////////////////////////////////////////
  // checking and waits
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  task automatic add_row(input logic [9:0] f, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] e);
    vectors.push_back('{func_id: f, in0: a, in1: b, expected: e});
  endtask

  // polls at falling edges until the DUT can take a command
  task automatic wait_cmd_ready();
    int polls;
    polls = 0;
    while (cmd_ready !== 1'b1) begin
      if (polls > 50) abort_run("timeout waiting for cmd_ready");
      @(negedge clk);
      polls++;
    end
  endtask

  // send one row, measure latency, stall the response, then release it
  task automatic run_row(input vec_t v, input int stall);
    int          edges;
    logic [31:0] held;
    wait_cmd_ready();
    cmd_valid               = 1'b1;
    cmd_payload_function_id = v.func_id;
    cmd_payload_inputs_0    = v.in0;
    cmd_payload_inputs_1    = v.in1;
    rsp_ready               = (stall == 0);
    // accepting edge k
    @(posedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
    // rising edges seen after edge k
    edges     = 0;
    while (rsp_valid !== 1'b1) begin
      check_value("cmd_ready", cmd_ready, 1'b0);
      if (edges > 20) abort_run("timeout waiting for rsp_valid");
      @(negedge clk);
      edges++;
    end
    // reads take one edge more than everything else
    check_value("rsp_latency", edges, (v.func_id[2:0] == 3'd4) ? 3 : 2);
    check_value("rsp_payload_outputs_0", rsp_payload_outputs_0, v.expected);
    held = rsp_payload_outputs_0;
    for (int s = 0; s < stall; s++) begin
      @(negedge clk);
      check_value("rsp_valid", rsp_valid, 1'b1);
      check_value("rsp_payload_outputs_0", rsp_payload_outputs_0, held);
      check_value("cmd_ready", cmd_ready, 1'b0);
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    // response taken and command slot open again
    check_value("rsp_valid", rsp_valid, 1'b0);
    check_value("cmd_ready", cmd_ready, 1'b1);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    int          stall;
    clk                     = 1'b0;
    resetn                  = 1'b0;
    cmd_valid               = 1'b0;
    cmd_payload_function_id = '0;
    cmd_payload_inputs_0    = '0;
    cmd_payload_inputs_1    = '0;
    rsp_ready               = 1'b0;
    void'($urandom(32'h7690_7513));

    // ALU corner values
    add_row(10'd0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, sum_bytes(32'hFFFF_FFFF, 32'hFFFF_FFFF));
    add_row(10'd0, 32'h0, 32'h0, 32'h0);
    add_row(10'd1, 32'h1234_5678, 32'h0, swap_bytes(32'h1234_5678));
    add_row(10'd1, 32'h0, 32'hFFFF_FFFF, 32'h0);
    add_row(10'd2, 32'h0000_0001, 32'h0, reverse_bits(32'h0000_0001));
    add_row(10'd2, 32'hFFFF_FFFF, 32'h0, 32'hFFFF_FFFF);
    // writes to the address in the low 9 bits of inputs_0
    add_row(10'd3, 32'h0000_0000, 32'hA5A5_0000, 32'hFFFF_FFFF);
    add_row(10'd3, 32'hFFFF_FFFF, 32'h5A5A_01FF, 32'hFFFF_FFFF);
    add_row(10'd3, 32'h0000_0025, 32'hC0DE_0025, 32'hFFFF_FFFF);
    add_row(10'd4, 32'h0000_0000, 32'h0, 32'hA5A5_0000);
    add_row(10'd4, 32'h0000_01FF, 32'h0, 32'h5A5A_01FF);
    // other addresses written before reading back again
    add_row(10'd3, 32'h0000_0064, 32'hD00D_0064, 32'hFFFF_FFFF);
    add_row(10'd3, 32'h0000_0001, 32'hE00E_0001, 32'hFFFF_FFFF);
    add_row(10'd4, 32'h1234_0025, 32'h0, 32'hC0DE_0025);
    add_row(10'd4, 32'h0000_0000, 32'h0, 32'hA5A5_0000);
    add_row(10'd4, 32'h0000_0064, 32'h0, 32'hD00D_0064);
    // unassigned opcodes
    for (int op = 5; op < 8; op++) begin
      add_row(10'(op), $urandom, $urandom, 32'h0);
    end
    // funct7 set on every opcode
    a = $urandom;
    b = $urandom;
    add_row({7'h7F, 3'd0}, a, b, sum_bytes(a, b));
    add_row({7'h55, 3'd1}, a, b, swap_bytes(a));
    add_row({7'h2A, 3'd2}, a, b, reverse_bits(a));
    add_row({7'h7F, 3'd5}, a, b, 32'h0);
    add_row({7'h33, 3'd6}, a, b, 32'h0);
    add_row({7'h01, 3'd7}, a, b, 32'h0);
    add_row({7'h40, 3'd3}, 32'h0000_01FF, 32'hF00D_CAFE, 32'hFFFF_FFFF);
    add_row({7'h7F, 3'd4}, 32'h8000_01FF, 32'h0, 32'hF00D_CAFE);
    // random ALU rows
    for (int i = 0; i < 12; i++) begin
      f3 = 3'($urandom_range(0, 2));
      a  = $urandom;
      b  = $urandom;
      add_row({7'd0, f3}, a, b, alu_expect(f3, a, b));
    end

    // reset for two cycles
    repeat (2) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    check_value("cmd_ready", cmd_ready, 1'b1);
    check_value("rsp_valid", rsp_valid, 1'b0);

    foreach (vectors[i]) begin
      // first row always stalls so back-pressure is seen at least once
      stall = (i == 0) ? 3 : int'($urandom_range(0, 4));
      run_row(vectors[i], stall);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hdl/cfu_pkg.sv
hdl/simd_byte_alu.sv
hdl/instr_store.sv
hdl/cfu_front_end.sv
hdl/cfu_top.sv
tests/tb_cfu.sv

//--- Bender.yml
package:
  name: cfu

sources:
  - target: rtl
    files:
      - hdl/cfu_pkg.sv
      - hdl/simd_byte_alu.sv
      - hdl/instr_store.sv
      - hdl/cfu_front_end.sv
      - hdl/cfu_top.sv
  - target: test
    files:
      - tests/tb_cfu.sv
